//--- stream_pkg.sv
package stream_pkg;

  // Payload word width in bits
  localparam int DATA_W = 32;

  // One payload word
  typedef logic [DATA_W-1:0] word_t;

  // One stream beat as stored by every FIFO stage
  typedef struct packed {
    word_t data;
    logic  last;
  } beat_t;

  // Width of the space and occupied counts
  localparam int FILL_W = 16;

  // Entry count as reported by each FIFO
  typedef logic [FILL_W-1:0] fill_t;

  // Occupied count of every stage in the chain
  typedef struct packed {
    fill_t stage0;
    fill_t stage1;
    fill_t stage2;
  } chain_level_t;

  // Log2 depth of each chain stage
  // 0 is a single register, 1 a skid pair, 4 a 16-entry shift register
  localparam int STAGE0_SIZE = 0;
  localparam int STAGE1_SIZE = 1;
  localparam int STAGE2_SIZE = 4;

  // Total beats the chain can hold (1 + 2 + 16)
  localparam int CHAIN_DEPTH = 19;

endpackage

//--- axi_fifo_flop.sv
`timescale 1ns/1ps

module axi_fifo_flop
  import stream_pkg::*;
(
  input  logic  clk,
  input  logic  i_arst_n,
  input  logic  i_clear,
  input  beat_t i_in_tdata,
  input  logic  i_in_tvalid,
  output logic  o_in_tready,
  output beat_t o_out_tdata,
  output logic  o_out_tvalid,
  input  logic  i_out_tready,
  output logic  o_space,
  output logic  o_occupied
);

  beat_t data_q;
  logic  full_q;
  logic  in_fire;
  logic  out_fire;

  // Accept when empty or when the held beat leaves this cycle
  assign o_in_tready = !full_q || i_out_tready;
  assign in_fire     = i_in_tvalid && o_in_tready;
  assign out_fire    = full_q && i_out_tready;

  // Full flag
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      full_q <= 1'b0;
    end else if (i_clear) begin
      full_q <= 1'b0;
    end else if (in_fire) begin
      full_q <= 1'b1;
    end else if (out_fire) begin
      full_q <= 1'b0;
    end
  end

  // Payload register loads on every accepted beat
  always_ff @(posedge clk) begin
    if (in_fire) begin
      data_q <= i_in_tdata;
    end
  end

  assign o_out_tdata  = data_q;
  assign o_out_tvalid = full_q;
  assign o_space      = !full_q;
  assign o_occupied   = full_q;

  // A stalled beat stays put until taken
  a_stall_stable : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (o_out_tvalid && !i_out_tready && !i_clear) |=> (o_out_tvalid && $stable(o_out_tdata))
  ) else $error("axi_fifo_flop output changed while stalled");

endmodule

//--- axi_fifo_flop2.sv
`timescale 1ns/1ps

module axi_fifo_flop2
  import stream_pkg::*;
(
  input  logic       clk,
  input  logic       i_arst_n,
  input  logic       i_clear,
  input  beat_t      i_in_tdata,
  input  logic       i_in_tvalid,
  output logic       o_in_tready,
  output beat_t      o_out_tdata,
  output logic       o_out_tvalid,
  input  logic       i_out_tready,
  output logic [1:0] o_space,
  output logic [1:0] o_occupied
);

  beat_t main_q;
  beat_t skid_q;
  logic  main_valid_q;
  logic  skid_valid_q;
  logic  ready_q;
  logic  main_valid_d;
  logic  skid_valid_d;
  logic  in_fire;
  logic  out_fire;
  logic  main_load;
  logic  skid_load;
  logic  main_from_skid;

  // Ready comes straight from a flop
  assign in_fire  = i_in_tvalid && ready_q;
  assign out_fire = main_valid_q && i_out_tready;

  // Next state for the main and skid slots
  always_comb begin
    main_valid_d   = main_valid_q;
    skid_valid_d   = skid_valid_q;
    main_load      = 1'b0;
    skid_load      = 1'b0;
    main_from_skid = 1'b0;
    if (out_fire) begin
      if (skid_valid_q) begin
        // Parked beat moves forward
        main_from_skid = 1'b1;
        skid_valid_d   = 1'b0;
      end else begin
        // Refill from the input or go empty
        main_load    = in_fire;
        main_valid_d = in_fire;
      end
    end else if (in_fire) begin
      if (main_valid_q) begin
        // Output stalled so park the new beat
        skid_load    = 1'b1;
        skid_valid_d = 1'b1;
      end else begin
        main_load    = 1'b1;
        main_valid_d = 1'b1;
      end
    end
  end

  // Control flops
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
      ready_q      <= 1'b1;
    end else if (i_clear) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
      ready_q      <= 1'b1;
    end else begin
      main_valid_q <= main_valid_d;
      skid_valid_q <= skid_valid_d;
      // Room stays while the skid slot is free
      ready_q      <= !skid_valid_d;
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (main_from_skid) begin
      main_q <= skid_q;
    end else if (main_load) begin
      main_q <= i_in_tdata;
    end
    if (skid_load) begin
      skid_q <= i_in_tdata;
    end
  end

  assign o_in_tready  = ready_q;
  assign o_out_tdata  = main_q;
  assign o_out_tvalid = main_valid_q;
  assign o_occupied   = {1'b0, main_valid_q} + {1'b0, skid_valid_q};
  assign o_space      = 2'd2 - o_occupied;

  // Registered ready must track the skid slot
  a_skid_no_overwrite : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    skid_load |-> !skid_valid_q
  ) else $error("axi_fifo_flop2 skid register written while full");

endmodule

//--- axi_fifo_short.sv
`timescale 1ns/1ps

module axi_fifo_short
  import stream_pkg::*;
#(
  parameter int SIZE = 5
) (
  input  logic       clk,
  input  logic       i_arst_n,
  input  logic       i_clear,
  input  beat_t      i_in_tdata,
  input  logic       i_in_tvalid,
  output logic       o_in_tready,
  output beat_t      o_out_tdata,
  output logic       o_out_tvalid,
  input  logic       i_out_tready,
  output logic [5:0] o_space,
  output logic [5:0] o_occupied
);

  localparam int DEPTH = 2 ** SIZE;
  localparam int CNT_W = SIZE + 1;

  // EMPTY nothing held, PRIMED only the output register, RUNNING entries queued
  typedef enum logic [1:0] {
    EMPTY,
    PRIMED,
    RUNNING
  } fifo_state_t;

  fifo_state_t      state_q;
  fifo_state_t      state_d;
  beat_t            srl_q [DEPTH];
  beat_t            out_q;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  logic [SIZE-1:0]  rd_idx;
  logic             out_valid;
  logic             out_valid_d;
  logic             out_take;
  logic             in_fire;
  logic             pop;
  logic             bypass;

  assign out_valid = (state_q != EMPTY);

  // Output register plus queued entries
  assign o_occupied  = 6'(cnt_q) + 6'(out_valid);
  assign o_space     = 6'(DEPTH) - o_occupied;
  assign o_in_tready = (o_occupied < 6'(DEPTH));

  assign in_fire  = i_in_tvalid && o_in_tready;
  // Output register free now or freed this cycle
  assign out_take = !out_valid || i_out_tready;
  // Oldest queued entry sits at the highest used index
  assign pop      = out_take && (state_q == RUNNING);
  // Nothing queued so the input goes straight to the output register
  assign bypass   = out_take && (state_q != RUNNING) && in_fire;
  assign rd_idx   = SIZE'(cnt_q - 1'b1);

  always_comb begin
    cnt_d = cnt_q;
    if (in_fire && !bypass) begin
      cnt_d = cnt_d + 1'b1;
    end
    if (pop) begin
      cnt_d = cnt_d - 1'b1;
    end
    if (out_take) begin
      out_valid_d = pop || bypass;
    end else begin
      out_valid_d = 1'b1;
    end
    if (!out_valid_d) begin
      state_d = EMPTY;
    end else if (cnt_d == '0) begin
      state_d = PRIMED;
    end else begin
      state_d = RUNNING;
    end
  end

  // State and read index
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= EMPTY;
      cnt_q   <= '0;
    end else if (i_clear) begin
      state_q <= EMPTY;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Shift register written at the head on every accept
  always_ff @(posedge clk) begin
    if (in_fire) begin
      srl_q[0] <= i_in_tdata;
      for (int i = 1; i < DEPTH; i++) begin
        srl_q[i] <= srl_q[i-1];
      end
    end
  end

  // Output register
  always_ff @(posedge clk) begin
    if (pop) begin
      out_q <= srl_q[rd_idx];
    end else if (bypass) begin
      out_q <= i_in_tdata;
    end
  end

  assign o_out_tdata  = out_q;
  assign o_out_tvalid = out_valid;

  // Read index stays inside the shift register
  a_idx_range : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    cnt_q <= CNT_W'(DEPTH)
  ) else $error("axi_fifo_short read index beyond capacity");

  // A queued write lands behind a loaded output register with room left
  a_no_write_full : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (in_fire && !bypass) |-> (out_valid && (cnt_q < CNT_W'(DEPTH - 1)))
  ) else $error("axi_fifo_short queued write while full");

endmodule

//--- axi_fifo.sv
`timescale 1ns/1ps

module axi_fifo
  import stream_pkg::*;
#(
  parameter int SIZE = 5
) (
  input  logic  clk,
  input  logic  i_arst_n,
  input  logic  i_clear,
  input  beat_t i_in_tdata,
  input  logic  i_in_tvalid,
  output logic  o_in_tready,
  output beat_t o_out_tdata,
  output logic  o_out_tvalid,
  input  logic  i_out_tready,
  output fill_t o_space,
  output fill_t o_occupied
);

  // Only register and shift-register variants exist
  if (SIZE > 5) begin : gen_size_check
    $fatal(1, "axi_fifo SIZE %0d above 5 is not supported", SIZE);
  end

  if (SIZE < 0) begin : gen_no_fifo
    // Straight wires and no storage
    assign o_out_tdata  = i_in_tdata;
    assign o_out_tvalid = i_in_tvalid;
    assign o_in_tready  = i_out_tready;
    assign o_space      = '0;
    assign o_occupied   = '0;
  end else if (SIZE == 0) begin : gen_fifo_flop
    logic space_1;
    logic occupied_1;

    axi_fifo_flop fifo_flop_i (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_clear      (i_clear),
      .i_in_tdata   (i_in_tdata),
      .i_in_tvalid  (i_in_tvalid),
      .o_in_tready  (o_in_tready),
      .o_out_tdata  (o_out_tdata),
      .o_out_tvalid (o_out_tvalid),
      .i_out_tready (i_out_tready),
      .o_space      (space_1),
      .o_occupied   (occupied_1)
    );

    // Zero-extend to the common count width
    assign o_space    = fill_t'(space_1);
    assign o_occupied = fill_t'(occupied_1);
  end else if (SIZE == 1) begin : gen_fifo_flop2
    logic [1:0] space_2;
    logic [1:0] occupied_2;

    axi_fifo_flop2 fifo_flop2_i (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_clear      (i_clear),
      .i_in_tdata   (i_in_tdata),
      .i_in_tvalid  (i_in_tvalid),
      .o_in_tready  (o_in_tready),
      .o_out_tdata  (o_out_tdata),
      .o_out_tvalid (o_out_tvalid),
      .i_out_tready (i_out_tready),
      .o_space      (space_2),
      .o_occupied   (occupied_2)
    );

    assign o_space    = fill_t'(space_2);
    assign o_occupied = fill_t'(occupied_2);
  end else begin : gen_fifo_short
    logic [5:0] space_6;
    logic [5:0] occupied_6;

    axi_fifo_short #(
      .SIZE (SIZE)
    ) fifo_short_i (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_clear      (i_clear),
      .i_in_tdata   (i_in_tdata),
      .i_in_tvalid  (i_in_tvalid),
      .o_in_tready  (o_in_tready),
      .o_out_tdata  (o_out_tdata),
      .o_out_tvalid (o_out_tvalid),
      .i_out_tready (i_out_tready),
      .o_space      (space_6),
      .o_occupied   (occupied_6)
    );

    assign o_space    = fill_t'(space_6);
    assign o_occupied = fill_t'(occupied_6);
  end

endmodule

//--- stream_buffer_chain.sv
`timescale 1ns/1ps

module stream_buffer_chain
  import stream_pkg::*;
(
  input  logic         clk,
  input  logic         i_arst_n,
  input  logic         i_clear,
  input  beat_t        i_in_tdata,
  input  logic         i_in_tvalid,
  output logic         o_in_tready,
  output beat_t        o_out_tdata,
  output logic         o_out_tvalid,
  input  logic         i_out_tready,
  output fill_t        o_space,
  output chain_level_t o_level
);

  // Stage 0 to stage 1 link
  beat_t s01_tdata;
  logic  s01_tvalid;
  logic  s01_tready;
  // Stage 1 to stage 2 link
  beat_t s12_tdata;
  logic  s12_tvalid;
  logic  s12_tready;

  // Single register at the chain input
  axi_fifo #(
    .SIZE (STAGE0_SIZE)
  ) stage0_i (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_clear      (i_clear),
    .i_in_tdata   (i_in_tdata),
    .i_in_tvalid  (i_in_tvalid),
    .o_in_tready  (o_in_tready),
    .o_out_tdata  (s01_tdata),
    .o_out_tvalid (s01_tvalid),
    .i_out_tready (s01_tready),
    .o_space      (o_space),
    .o_occupied   (o_level.stage0)
  );

  // Skid pair breaks the ready path
  axi_fifo #(
    .SIZE (STAGE1_SIZE)
  ) stage1_i (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_clear      (i_clear),
    .i_in_tdata   (s01_tdata),
    .i_in_tvalid  (s01_tvalid),
    .o_in_tready  (s01_tready),
    .o_out_tdata  (s12_tdata),
    .o_out_tvalid (s12_tvalid),
    .i_out_tready (s12_tready),
    .o_space      (),
    .o_occupied   (o_level.stage1)
  );

  // Deep shift-register buffer at the chain output
  axi_fifo #(
    .SIZE (STAGE2_SIZE)
  ) stage2_i (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_clear      (i_clear),
    .i_in_tdata   (s12_tdata),
    .i_in_tvalid  (s12_tvalid),
    .o_in_tready  (s12_tready),
    .o_out_tdata  (o_out_tdata),
    .o_out_tvalid (o_out_tvalid),
    .i_out_tready (i_out_tready),
    .o_space      (),
    .o_occupied   (o_level.stage2)
  );

  // Summed stage occupancy never beyond the chain capacity
  a_chain_capacity : assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (int'(o_level.stage0) + int'(o_level.stage1) + int'(o_level.stage2)) <= CHAIN_DEPTH
  ) else $error("stream_buffer_chain holds more than CHAIN_DEPTH beats");

endmodule

//--- tb_stream_buffer_chain.sv
`timescale 1ns/1ps

module tb_stream_buffer_chain
  import stream_pkg::*;
();

  logic         clk;
  logic         i_arst_n;
  logic         i_clear;
  beat_t        i_in_tdata;
  logic         i_in_tvalid;
  logic         o_in_tready;
  beat_t        o_out_tdata;
  logic         o_out_tvalid;
  logic         i_out_tready;
  fill_t        o_space;
  chain_level_t o_level;

  // Beats accepted by the chain and not yet seen at the output, oldest first
  beat_t  exp_q[$];
  // Beat on offer at the input, held until accepted
  beat_t  in_beat;
  logic   pending;
  integer seed;
  int     gen_cnt;
  int     accepted;
  int     cycle_cnt;

  stream_buffer_chain stream_buffer_chain_i (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_clear      (i_clear),
    .i_in_tdata   (i_in_tdata),
    .i_in_tvalid  (i_in_tvalid),
    .o_in_tready  (o_in_tready),
    .o_out_tdata  (o_out_tdata),
    .o_out_tvalid (o_out_tvalid),
    .i_out_tready (i_out_tready),
    .o_space      (o_space),
    .o_level      (o_level)
  );

  // 20 ns clock
  always #10 clk = ~clk;

  // Limit near four times the roughly 450 cycles of all tests
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= 2000) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_cnt);
      $display("CHECKS FAILED");
      $fatal(1, "Simulation stopped on timeout");
    end
  end

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[FAIL] %0t ns: %s got 0x%0h expected 0x%0h", $time, what, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // Total beats held over all three stages
  function automatic int level_sum();
    return int'(o_level.stage0) + int'(o_level.stage1) + int'(o_level.stage2);
  endfunction

  // Drive one cycle on the falling edge and score the handshakes
  // that the next rising edge will complete
  task automatic run_cycle(input logic offer, input logic take);
    @(negedge clk);
    if (!pending && offer) begin
      in_beat.data = $random(seed);
      // Every tenth beat closes a packet
      in_beat.last = (gen_cnt % 10 == 9);
      gen_cnt++;
      pending = 1'b1;
    end
    i_in_tvalid  = pending;
    i_in_tdata   = in_beat;
    i_out_tready = take;
    #1;
    // Counts are registered and reflect everything accepted so far
    check_equal(level_sum(), exp_q.size(), "summed o_level against model");
    if (o_out_tvalid && take) begin
      check_equal(exp_q.size() != 0, 1'b1, "output beat with no beat sent");
      check_equal(o_out_tdata, exp_q[0], "output beat");
      void'(exp_q.pop_front());
    end
    if (pending && o_in_tready) begin
      exp_q.push_back(in_beat);
      pending = 1'b0;
      accepted++;
    end
  endtask

  // Output open until the model and the input are both empty
  task automatic drain();
    while (pending || exp_q.size() != 0) begin
      run_cycle(1'b0, 1'b1);
    end
  endtask

  task automatic test_reset();
    @(negedge clk);
    #1;
    check_equal(o_out_tvalid, 1'b0, "o_out_tvalid after reset");
    check_equal(o_in_tready, 1'b1, "o_in_tready after reset");
    check_equal(o_level, '0, "o_level after reset");
    check_equal(o_space, 1 << STAGE0_SIZE, "o_space after reset");
  endtask

  task automatic test_stream();
    int start;
    start = accepted;
    while (accepted - start < 50) begin
      run_cycle(1'b1, 1'b1);
    end
    drain();
  endtask

  task automatic test_fill();
    int start;
    int stalled;
    start   = accepted;
    stalled = 0;
    // Keep offering until ready has been low for a while
    while (stalled < 8) begin
      run_cycle(1'b1, 1'b0);
      if (pending) begin
        stalled++;
      end else begin
        stalled = 0;
      end
    end
    check_equal(accepted - start, CHAIN_DEPTH, "beats accepted into full chain");
    check_equal(o_level.stage0, 1 << STAGE0_SIZE, "stage0 level when full");
    check_equal(o_level.stage1, 1 << STAGE1_SIZE, "stage1 level when full");
    check_equal(o_level.stage2, 1 << STAGE2_SIZE, "stage2 level when full");
    check_equal(o_space, 0, "o_space when full");
    drain();
  endtask

  task automatic test_stalls();
    logic offer;
    logic take;
    repeat (200) begin
      offer = $random(seed);
      take  = $random(seed);
      run_cycle(offer, take);
    end
    drain();
  endtask

  task automatic test_clear();
    int start;
    start = accepted;
    while (accepted - start < 6) begin
      run_cycle(1'b1, 1'b0);
    end
    // Let the beats spread into the deeper stages
    repeat (4) begin
      run_cycle(1'b0, 1'b0);
    end
    check_equal(level_sum(), 6, "level before clear");
    @(negedge clk);
    i_in_tvalid  = 1'b0;
    i_out_tready = 1'b0;
    i_clear      = 1'b1;
    @(negedge clk);
    i_clear = 1'b0;
    #1;
    check_equal(o_level, '0, "o_level after clear");
    check_equal(o_out_tvalid, 1'b0, "o_out_tvalid after clear");
    check_equal(o_space, 1 << STAGE0_SIZE, "o_space after clear");
    // Cleared beats are gone for good
    exp_q.delete();
    repeat (10) begin
      run_cycle(1'b1, 1'b1);
    end
    drain();
  endtask

  initial begin
    clk          = 1'b0;
    i_arst_n     = 1'b0;
    i_clear      = 1'b0;
    i_in_tdata   = '0;
    i_in_tvalid  = 1'b0;
    i_out_tready = 1'b0;
    in_beat      = '0;
    pending      = 1'b0;
    seed         = 13;
    gen_cnt      = 0;
    accepted     = 0;
    cycle_cnt    = 0;
    // Three cycles of reset, released on a falling edge
    repeat (3) @(posedge clk);
    @(negedge clk);
    i_arst_n = 1'b1;
    test_reset();
    test_stream();
    test_fill();
    test_stalls();
    test_clear();
    // Chain must be empty once the last expected beat has left
    @(negedge clk);
    #1;
    check_equal(o_out_tvalid, 1'b0, "o_out_tvalid after final drain");
    check_equal(o_level, '0, "o_level after final drain");
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- sim.f
stream_pkg.sv
axi_fifo_flop.sv
axi_fifo_flop2.sv
axi_fifo_short.sv
axi_fifo.sv
stream_buffer_chain.sv
tb_stream_buffer_chain.sv

//--- Bender.yml
package:
  name: stream_buffer_chain

sources:
  - stream_pkg.sv
  - axi_fifo_flop.sv
  - axi_fifo_flop2.sv
  - axi_fifo_short.sv
  - axi_fifo.sv
  - stream_buffer_chain.sv
  - target: simulation
    files:
      - tb_stream_buffer_chain.sv
